// ==== hw/chdr_pkg.sv ====
/*
 * CHDR stream definitions shared by the swap datapath: header field layout,
 * packet-type codes and the beat struct carried on every valid/ready link.
 */
`default_nettype none

package chdr_pkg;

  // Bus width, a multiple of 64
  localparam int CHDR_W = 64;
  localparam int NUM_LANES = CHDR_W / 64;

  // Header field positions within the low 64 bits
  localparam int PKT_TYPE_LSB = 53;
  localparam int NUM_MDATA_LSB = 20;

  typedef logic [2:0] pkt_type_t;
  typedef logic [4:0] num_mdata_t;

  // Data packets, with and without timestamp
  localparam pkt_type_t PKT_DATA = 3'd6;
  localparam pkt_type_t PKT_DATA_TS = 3'd7;

  typedef struct packed {
    logic [CHDR_W-1:0] data;
    logic              last;
  } chdr_beat_t;

  function automatic pkt_type_t get_pkt_type(input logic [63:0] hdr);
    return hdr[PKT_TYPE_LSB +: $bits(pkt_type_t)];
  endfunction

  function automatic num_mdata_t get_num_mdata(input logic [63:0] hdr);
    return hdr[NUM_MDATA_LSB +: $bits(num_mdata_t)];
  endfunction

endpackage

`default_nettype wire

// ==== hw/swap_pkg.sv ====
/*
 * Software buffer modes and the element-swap map derived from them.
 */
`default_nettype none

package swap_pkg;

  typedef enum logic [1:0] {
    BUFF_U64 = 2'd0,
    BUFF_U32 = 2'd1,
    BUFF_U16 = 2'd2,
    BUFF_U8  = 2'd3
  } sw_buff_t;

  // Bit 0 swaps bytes, bit 1 swaps 16-bit halves, bit 2 swaps 32-bit halves
  typedef logic [2:0] swap_map_t;
  localparam swap_map_t MAP_IDENTITY = 3'b000;

  typedef struct packed {
    sw_buff_t payload;
    sw_buff_t mdata;
  } swap_cfg_t;

  localparam swap_cfg_t CFG_DEFAULT = '{payload: BUFF_U64, mdata: BUFF_U64};

  function automatic swap_map_t map_of_buff(input sw_buff_t buff);
    case (buff)
      BUFF_U8:  return 3'b111;
      BUFF_U16: return 3'b110;
      BUFF_U32: return 3'b100;
      default:  return MAP_IDENTITY;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== hw/chdr_swap_cfg.sv ====
/*
 * Slave side of the four-phase config handshake. Holds the buffer modes
 * until the swapper picks them up at the next packet header.
 */
`timescale 1ns/1ns
`default_nettype none

module chdr_swap_cfg (
  input  logic                clk,
  input  logic                rst,
  // Four-phase request and acknowledge
  input  logic                cfg_req,
  output logic                cfg_ack,
  input  swap_pkg::swap_cfg_t cfg_in,
  // Modes waiting for the next header
  output swap_pkg::swap_cfg_t pending_cfg
);

  import swap_pkg::*;

  // Ack follows req with one cycle of delay; modes load on the new request
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_ack     <= 1'b0;
      pending_cfg <= CFG_DEFAULT;
    end else begin
      cfg_ack <= cfg_req;
      if (cfg_req && !cfg_ack) begin
        pending_cfg <= cfg_in;
      end
    end
  end

  // Ack never rises while the request is low
  ack_follows_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(cfg_ack) |-> cfg_req
  );

  // Master keeps the modes steady for the whole request phase
  cfg_in_stable: assert property (
    @(posedge clk) disable iff (rst)
    (cfg_req && $past(cfg_req)) |-> $stable(cfg_in)
  );

endmodule

`default_nettype wire

// ==== hw/chdr_lane_swap.sv ====
/*
 * One registered stage that reverses 8/16/32-bit elements inside every
 * 64-bit lane, as selected by the swap map that travels with the beat.
 */
`timescale 1ns/1ns
`default_nettype none

module chdr_lane_swap (
  input  logic                 clk,
  input  logic                 rst,
  input  chdr_pkg::chdr_beat_t s_beat,
  input  swap_pkg::swap_map_t  s_map,
  input  logic                 s_valid,
  output logic                 s_ready,
  output chdr_pkg::chdr_beat_t m_beat,
  output logic                 m_valid,
  input  logic                 m_ready
);

  import chdr_pkg::*;
  import swap_pkg::*;

  logic [CHDR_W-1:0] swapped;

  // 32-bit swap first, then 16-bit, then bytes; all three reverse bytes
  function automatic logic [63:0] swap_lane(input logic [63:0] word, input swap_map_t map);
    logic [63:0] res;
    res = word;
    if (map[2]) begin
      res = {res[31:0], res[63:32]};
    end
    if (map[1]) begin
      res = {res[47:32], res[63:48], res[15:0], res[31:16]};
    end
    if (map[0]) begin
      res = {res[55:48], res[63:56], res[39:32], res[47:40],
             res[23:16], res[31:24], res[7:0], res[15:8]};
    end
    return res;
  endfunction

  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
    assign swapped[lane*64 +: 64] = swap_lane(s_beat.data[lane*64 +: 64], s_map);
  end

  // Accept when the register is empty or emptying this cycle
  assign s_ready = !m_valid || m_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      m_beat.data <= swapped;
      m_beat.last <= s_beat.last;
    end
  end

  out_held: assert property (
    @(posedge clk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
  );

endmodule

`default_nettype wire

// ==== hw/chdr_data_swapper.sv ====
/*
 * Tracks the position of each word in a CHDR packet and picks the swap map
 * for it; the lane swap stage then reorders metadata and data-body words.
 */
`timescale 1ns/1ns
`default_nettype none

module chdr_data_swapper (
  input  logic                 clk,
  input  logic                 rst,
  input  swap_pkg::swap_cfg_t  pending_cfg,
  // Input stream
  input  chdr_pkg::chdr_beat_t s_beat,
  input  logic                 s_valid,
  output logic                 s_ready,
  // Output stream
  output chdr_pkg::chdr_beat_t m_beat,
  output logic                 m_valid,
  input  logic                 m_ready
);

  import chdr_pkg::*;
  import swap_pkg::*;

  typedef enum logic [2:0] {
    ST_HDR   = 3'd0,
    ST_TS    = 3'd1,
    ST_MDATA = 3'd2,
    ST_BODY  = 3'd3,
    ST_OTHER = 3'd4
  } state_t;

  state_t     state;
  num_mdata_t mdata_left;
  swap_cfg_t  active_cfg;
  swap_map_t  s_map;
  pkt_type_t  pkt_type;
  num_mdata_t num_mdata;
  logic       accept;
  logic       is_data;

  // Header fields are only meaningful in ST_HDR
  assign pkt_type  = get_pkt_type(s_beat.data[63:0]);
  assign num_mdata = get_num_mdata(s_beat.data[63:0]);
  assign is_data   = (pkt_type == PKT_DATA) || (pkt_type == PKT_DATA_TS);
  assign accept    = s_valid && s_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_HDR;
      mdata_left <= '0;
      active_cfg <= CFG_DEFAULT;
    end else if (accept) begin
      if (state == ST_HDR) begin
        // New modes take effect only at a packet boundary
        active_cfg <= pending_cfg;
        mdata_left <= num_mdata;
      end else if (state == ST_MDATA) begin
        mdata_left <= mdata_left - 1'b1;
      end

      if (s_beat.last) begin
        state <= ST_HDR;
      end else begin
        case (state)
          ST_HDR: begin
            if (!is_data) begin
              state <= ST_OTHER;
            end else if (CHDR_W == 64 && pkt_type == PKT_DATA_TS) begin
              // On a 64-bit bus the timestamp gets its own word
              state <= ST_TS;
            end else if (num_mdata != '0) begin
              state <= ST_MDATA;
            end else begin
              state <= ST_BODY;
            end
          end
          ST_TS: begin
            state <= (mdata_left != '0) ? ST_MDATA : ST_BODY;
          end
          ST_MDATA: begin
            if (mdata_left == num_mdata_t'(1)) begin
              state <= ST_BODY;
            end
          end
          ST_BODY, ST_OTHER: begin
            state <= state;
          end
          default: begin
            state <= ST_HDR;
          end
        endcase
      end
    end
  end

  // Header, timestamp and non-data payloads stay as u64
  always_comb begin
    case (state)
      ST_MDATA: s_map = map_of_buff(active_cfg.mdata);
      ST_BODY:  s_map = map_of_buff(active_cfg.payload);
      default:  s_map = MAP_IDENTITY;
    endcase
  end

  chdr_lane_swap chdr_lane_swap_i (
    .clk    (clk),
    .rst    (rst),
    .s_beat (s_beat),
    .s_map  (s_map),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .m_beat (m_beat),
    .m_valid(m_valid),
    .m_ready(m_ready)
  );

  state_legal: assert property (
    @(posedge clk) disable iff (rst)
    state inside {ST_HDR, ST_TS, ST_MDATA, ST_BODY, ST_OTHER}
  );

endmodule

`default_nettype wire

// ==== hw/chdr_out_fifo.sv ====
/*
 * Output beat FIFO: DEPTH entries in a circular buffer behind a registered
 * output. A beat written while everything is empty goes straight out.
 */
`timescale 1ns/1ns
`default_nettype none

module chdr_out_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  chdr_pkg::chdr_beat_t s_beat,
  input  logic                 s_valid,
  output logic                 s_ready,
  output chdr_pkg::chdr_beat_t m_beat,
  output logic                 m_valid,
  input  logic                 m_ready
);

  import chdr_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W+1)'(DEPTH);

  chdr_beat_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             out_free;
  logic             push;
  logic             bypass;
  logic             mem_wr;
  logic             mem_rd;

  assign s_ready  = (count != FULL_COUNT);
  assign out_free = !m_valid || m_ready;
  assign push     = s_valid && s_ready;
  // Skip the buffer only when nothing older is waiting in it
  assign bypass   = push && out_free && (count == '0);
  assign mem_rd   = out_free && (count != '0);
  assign mem_wr   = push && !bypass;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      m_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (mem_wr && !mem_rd) begin
        count <= count + 1'b1;
      end else if (mem_rd && !mem_wr) begin
        count <= count - 1'b1;
      end
      if (out_free) begin
        m_valid <= bypass || mem_rd;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= s_beat;
    end
    if (mem_rd) begin
      m_beat <= mem[rd_ptr];
    end else if (bypass) begin
      m_beat <= s_beat;
    end
  end

  no_write_when_full: assert property (
    @(posedge clk) disable iff (rst)
    mem_wr |-> (count < FULL_COUNT)
  );

endmodule

`default_nettype wire

// ==== hw/chdr_swap_top.sv ====
/*
 * CHDR buffer-mode adapter: config port, element swapper and output FIFO.
 */
`timescale 1ns/1ns
`default_nettype none

module chdr_swap_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  // Configuration
  input  logic                 cfg_req,
  output logic                 cfg_ack,
  input  swap_pkg::swap_cfg_t  cfg_in,
  // Input stream
  input  chdr_pkg::chdr_beat_t s_beat,
  input  logic                 s_valid,
  output logic                 s_ready,
  // Output stream
  output chdr_pkg::chdr_beat_t m_beat,
  output logic                 m_valid,
  input  logic                 m_ready
);

  import chdr_pkg::*;
  import swap_pkg::*;

  swap_cfg_t  pending_cfg;
  chdr_beat_t swap_beat;
  logic       swap_valid;
  logic       swap_ready;

  chdr_swap_cfg chdr_swap_cfg_i (
    .clk        (clk),
    .rst        (rst),
    .cfg_req    (cfg_req),
    .cfg_ack    (cfg_ack),
    .cfg_in     (cfg_in),
    .pending_cfg(pending_cfg)
  );

  chdr_data_swapper chdr_data_swapper_i (
    .clk        (clk),
    .rst        (rst),
    .pending_cfg(pending_cfg),
    .s_beat     (s_beat),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .m_beat     (swap_beat),
    .m_valid    (swap_valid),
    .m_ready    (swap_ready)
  );

  chdr_out_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) chdr_out_fifo_i (
    .clk    (clk),
    .rst    (rst),
    .s_beat (swap_beat),
    .s_valid(swap_valid),
    .s_ready(swap_ready),
    .m_beat (m_beat),
    .m_valid(m_valid),
    .m_ready(m_ready)
  );

endmodule

`default_nettype wire

// ==== verification/chdr_swap_tb.sv ====
/*
 * Self-checking testbench for the CHDR swap adapter. Replays the pattern file
 * through the config port and the input stream and checks every output beat.
 */
`timescale 1ns/1ns
`default_nettype none

module chdr_swap_tb;

  import chdr_pkg::*;
  import swap_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_LINES = 32;
  localparam int COLS = 4;

  // Line kinds in the pattern file
  localparam logic [63:0] KIND_EOF = 64'd0;
  localparam logic [63:0] KIND_CFG = 64'd1;
  localparam logic [63:0] KIND_WORD = 64'd2;
  localparam logic [63:0] KIND_END = 64'd3;

  logic        clk;
  logic        rst;
  logic        cfg_req;
  logic        cfg_ack;
  swap_cfg_t   cfg_in;
  chdr_beat_t  s_beat;
  logic        s_valid;
  logic        s_ready;
  chdr_beat_t  m_beat;
  logic        m_valid;
  logic        m_ready;

  logic [63:0] pat [MAX_LINES*COLS];
  logic [63:0] exp_data_q [$];
  logic        exp_last_q [$];
  int          num_lines = 0;
  int          errors = 0;
  int          checked = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          seed = 24402;
  logic        loaded = 1'b0;

  chdr_swap_top #(
    .FIFO_DEPTH(4)
  ) chdr_swap_top_i (
    .clk    (clk),
    .rst    (rst),
    .cfg_req(cfg_req),
    .cfg_ack(cfg_ack),
    .cfg_in (cfg_in),
    .s_beat (s_beat),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .m_beat (m_beat),
    .m_valid(m_valid),
    .m_ready(m_ready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  // Random back-pressure, about three cycles in four ready
  always @(negedge clk) begin
    m_ready = ($random(seed) % 4) != 0;
  end

  // Output beats are compared in order with the expected words
  always @(posedge clk) begin
    if (!rst && m_valid && m_ready) begin
      if (exp_data_q.size() == 0) begin
        $display("Output beat arrived with no word left to expect: %h", m_beat.data);
        errors++;
      end else begin
        if (m_beat.data !== exp_data_q[0]) begin
          $display("Fail m_beat.data: expected %h, got %h", exp_data_q[0], m_beat.data);
          errors++;
        end
        if (m_beat.last !== exp_last_q[0]) begin
          $display("Fail m_beat.last: expected %h, got %h", exp_last_q[0], m_beat.last);
          errors++;
        end
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
        checked++;
      end
    end
  end

  // Master side of the four-phase handshake, called on a falling edge
  task automatic send_config(input logic [3:0] modes);
    if (cfg_ack !== 1'b0) begin
      $display("Fail cfg_ack: expected %h, got %h before the request", 1'b0, cfg_ack);
      errors++;
    end
    cfg_in.payload = sw_buff_t'(modes[3:2]);
    cfg_in.mdata = sw_buff_t'(modes[1:0]);
    cfg_req = 1'b1;
    do @(negedge clk); while (cfg_ack !== 1'b1);
    // Ack has to stay up while the request is held
    @(negedge clk);
    if (cfg_ack !== 1'b1) begin
      $display("Fail cfg_ack: expected %h, got %h while cfg_req high", 1'b1, cfg_ack);
      errors++;
    end
    cfg_req = 1'b0;
    do @(negedge clk); while (cfg_ack !== 1'b0);
  endtask

  // Holds one word on the input until it transfers
  task automatic send_word(input logic [63:0] data, input logic last);
    s_beat.data = data;
    s_beat.last = last;
    s_valid = 1'b1;
    do @(posedge clk); while (!s_ready);
    @(negedge clk);
    s_valid = 1'b0;
  endtask

  initial begin
    int          line;
    int          base;
    int          test_num;
    int          err_start;
    int          chk_start;
    logic [63:0] kind;
    rst = 1'b1;
    cfg_req = 1'b0;
    cfg_in = CFG_DEFAULT;
    s_beat = '0;
    s_valid = 1'b0;
    m_ready = 1'b0;
    for (line = 0; line < MAX_LINES*COLS; line++) begin
      pat[line] = '0;
    end
    $readmemh("verification/chdr_swap_patterns.txt", pat);
    while (num_lines < MAX_LINES && pat[num_lines*COLS] != KIND_EOF) begin
      num_lines++;
    end
    loaded = 1'b1;
    if (num_lines == 0) begin
      $display("Pattern file holds no lines");
      errors++;
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (m_valid !== 1'b0) begin
      $display("Fail m_valid: expected %h, got %h after reset", 1'b0, m_valid);
      errors++;
    end
    if (s_ready !== 1'b1) begin
      $display("Fail s_ready: expected %h, got %h after reset", 1'b1, s_ready);
      errors++;
    end

    test_num = 1;
    err_start = errors;
    chk_start = checked;
    for (line = 0; line < num_lines; line++) begin
      base = line * COLS;
      kind = pat[base];
      case (kind)
        KIND_CFG: send_config(pat[base+2][3:0]);
        KIND_WORD: begin
          exp_data_q.push_back(pat[base+3]);
          exp_last_q.push_back(pat[base+1][0]);
          send_word(pat[base+2], pat[base+1][0]);
        end
        KIND_END: begin
          // Test is done once every expected word has come out
          while (exp_data_q.size() != 0) @(negedge clk);
          if (errors == err_start) begin
            tests_passed++;
          end else begin
            tests_failed++;
          end
          $display("Test %0d finished: %0d words checked, %0d errors",
                   test_num, checked - chk_start, errors - err_start);
          test_num++;
          err_start = errors;
          chk_start = checked;
        end
        default: begin
          $display("Unknown line kind %h in the pattern file", kind);
          errors++;
        end
      endcase
    end

    // Catch any stray beat after the last test
    repeat (10) @(negedge clk);
    $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog sized from the pattern count
  initial begin
    wait (loaded);
    #((num_lines * 50 + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the output stopped before every expected word arrived");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/chdr_swap_patterns.txt ====
// kind last in_word exp_word; kind 1 config (in_word = payload*4 + mdata), 2 word,
// 3 end of test, 0 end of file; modes 0 u64, 1 u32, 2 u16, 3 u8
1 0 0000000000000000 0000000000000000
2 0 00e0000000200030 00e0000000200030
2 0 0000000012345678 0000000012345678
2 0 0102030405060708 0102030405060708
2 0 1112131415161718 1112131415161718
2 1 0011223344556677 0011223344556677
3 0 0000000000000000 0000000000000000
1 0 000000000000000c 0000000000000000
2 0 00c0000000000018 00c0000000000018
2 0 0011223344556677 7766554433221100
2 1 8899aabbccddeeff ffeeddccbbaa9988
3 0 0000000000000000 0000000000000000
1 0 0000000000000009 0000000000000000
2 0 00e0000000100028 00e0000000100028
2 0 00000000abcdef01 00000000abcdef01
2 0 0102030405060708 0506070801020304
2 1 8899aabbccddeeff eeffccddaabb8899
3 0 0000000000000000 0000000000000000
1 0 000000000000000f 0000000000000000
2 0 0000000000100010 0000000000100010
2 1 0011223344556677 0011223344556677
1 0 0000000000000007 0000000000000000
2 0 00c0000000100020 00c0000000100020
2 0 0102030405060708 0807060504030201
2 1 0011223344556677 4455667700112233
3 0 0000000000000000 0000000000000000
0 0 0000000000000000 0000000000000000

// ==== sim.f ====
hw/chdr_pkg.sv
hw/swap_pkg.sv
hw/chdr_swap_cfg.sv
hw/chdr_lane_swap.sv
hw/chdr_data_swapper.sv
hw/chdr_out_fifo.sv
hw/chdr_swap_top.sv
verification/chdr_swap_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the CHDR swap adapter
VERILATOR  := verilator
TOP        := chdr_swap_tb
RTL_TOP    := chdr_swap_top
FILELIST   := sim.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
